// ==== cordic_macros.svh ====
// sizing for the sin/cos CORDIC; angles beyond +/-ANGLE_LIMIT codes overflow the 14-bit word
`ifndef CORDIC_MACROS_SVH
`define CORDIC_MACROS_SVH

// number of micro-rotations in the pipeline
`define CORDIC_STAGES 12

// input angle and output samples, Q1.6 signed
`define ANGLE_W 8

// internal datapath word, Q1.12 signed
`define WORD_W 14

// distance between the input and internal binary points
`define FRAC_SHIFT 6

// x seed, the inverse of the CORDIC gain (about 0.6072)
`define CORDIC_GAIN 14'b00_100110110111

// largest angle magnitude in input codes, 100/64 rad
`define ANGLE_LIMIT 100

`endif

// ==== cordic_fmt_pkg.sv ====
// number formats and arctangent table; atan_entry returns 0 for stage indices past 11
`include "cordic_macros.svh"

package cordic_fmt_pkg;

    // signed Q1.6 angle in radians, also used for sine and cosine samples
    typedef logic signed [`ANGLE_W-1:0] angle_t;

    // signed Q1.12 internal value
    typedef logic signed [`WORD_W-1:0] word_t;

    // atan(2^-idx) scaled by 4096 and rounded to nearest
    function automatic word_t atan_entry(input int unsigned idx);
        word_t val;
        case (idx)
            0:       val = word_t'(3217);
            1:       val = word_t'(1899);
            2:       val = word_t'(1003);
            3:       val = word_t'(509);
            4:       val = word_t'(256);
            5:       val = word_t'(128);
            6:       val = word_t'(64);
            7:       val = word_t'(32);
            8:       val = word_t'(16);
            9:       val = word_t'(8);
            10:      val = word_t'(4);
            11:      val = word_t'(2);
            // below one LSB from here on
            default: val = '0;
        endcase
        return val;
    endfunction

endpackage

// ==== cordic_pipe_pkg.sv ====
// records passed between CORDIC pipeline stages; data fields carry no reset value
package cordic_pipe_pkg;

    import cordic_fmt_pkg::*;

    // one in-flight sample between rotator stages
    typedef struct packed {
        logic  valid;
        // sign of the original angle, restored on the sine at the end
        logic  neg;
        word_t x;
        word_t y;
        // residual angle still to be rotated away
        word_t z;
    } stage_t;

    // rounded sample between the rounding and output registers
    typedef struct packed {
        logic   valid;
        logic   neg;
        angle_t sine;
        angle_t cosine;
    } result_t;

endpackage

// ==== angle_fold.sv ====
// input stage; angle must stay within +/-ANGLE_LIMIT codes, -128 is not folded correctly
`include "cordic_macros.svh"

module angle_fold
    import cordic_fmt_pkg::*, cordic_pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  angle_t angle,
    output stage_t stage
);

    angle_t angle_mag;
    word_t  z_init;

    // rotation only covers the first quadrant, so fold to the magnitude
    assign angle_mag = angle[`ANGLE_W-1] ? -angle : angle;

    // Q1.6 to Q1.12
    assign z_init = word_t'(angle_mag) <<< `FRAC_SHIFT;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        stage.neg <= angle[`ANGLE_W-1];
        stage.z   <= z_init;
        // start on the x axis, pre-scaled by the inverse gain
        stage.x   <= word_t'(`CORDIC_GAIN);
        stage.y   <= '0;
    end

endmodule

// ==== cordic_rotator.sv ====
// one registered micro-rotation; STAGE_IDX must be below WORD_W for a meaningful shift
`include "cordic_macros.svh"

module cordic_rotator
    import cordic_fmt_pkg::*, cordic_pipe_pkg::*;
#(
    parameter int unsigned STAGE_IDX = 0
) (
    input  logic   clk,
    input  logic   rst_n,
    input  stage_t stage_in,
    output stage_t stage_out
);

    // elementary angle for this stage, fixed at elaboration
    localparam word_t ATAN_STEP = atan_entry(STAGE_IDX);

    word_t x_sh;
    word_t y_sh;
    logic  z_neg;

    // scaling by 2^-i is an arithmetic shift
    assign x_sh  = stage_in.x >>> STAGE_IDX;
    assign y_sh  = stage_in.y >>> STAGE_IDX;
    assign z_neg = stage_in.z[`WORD_W-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_out.valid <= 1'b0;
        end else begin
            stage_out.valid <= stage_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        stage_out.neg <= stage_in.neg;
        if (z_neg) begin
            // overshot, rotate clockwise
            stage_out.x <= stage_in.x + y_sh;
            stage_out.y <= stage_in.y - x_sh;
            stage_out.z <= stage_in.z + ATAN_STEP;
        end else begin
            // still short of the target, rotate counter-clockwise
            stage_out.x <= stage_in.x - y_sh;
            stage_out.y <= stage_in.y + x_sh;
            stage_out.z <= stage_in.z - ATAN_STEP;
        end
    end

endmodule

// ==== sincos_round.sv ====
// two-cycle output stage; results keep the truncating quirk of the bit-12 rounding rule
`include "cordic_macros.svh"

module sincos_round
    import cordic_fmt_pkg::*, cordic_pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  stage_t stage,
    output logic   out_valid,
    output angle_t sine,
    output angle_t cosine
);

    result_t rnd;

    // Q1.12 to Q1.6
    // values with bit 12 set are close to 1.0 and are truncated so the +1
    // carry cannot reach the sign bit
    function automatic angle_t round_word(input word_t w);
        logic [`ANGLE_W-2:0] frac;
        angle_t              res;
        frac = w[`WORD_W-2:`FRAC_SHIFT] + (`ANGLE_W - 1)'(w[`FRAC_SHIFT-1]);
        if (!w[`WORD_W-2]) begin
            res = {w[`WORD_W-1], frac};
        end else begin
            res = w[`WORD_W-1:`FRAC_SHIFT];
        end
        return res;
    endfunction

    // rounding register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rnd.valid <= 1'b0;
        end else begin
            rnd.valid <= stage.valid;
        end
    end

    always_ff @(posedge clk) begin
        rnd.neg    <= stage.neg;
        // sine comes off y and cosine off x of the single rotation
        rnd.sine   <= round_word(stage.y);
        rnd.cosine <= round_word(stage.x);
    end

    // output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rnd.valid;
        end
    end

    always_ff @(posedge clk) begin
        // sine is odd, cosine is even
        sine   <= rnd.neg ? -rnd.sine : rnd.sine;
        cosine <= rnd.cosine;
    end

endmodule

// ==== cordic_sincos.sv ====
// 15-cycle sin/cos pipeline, one angle per cycle, no back-pressure; |angle| <= ANGLE_LIMIT
`include "cordic_macros.svh"

module cordic_sincos
    import cordic_fmt_pkg::*, cordic_pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  angle_t angle,
    output logic   out_valid,
    output angle_t sine,
    output angle_t cosine
);

    // chain[0] from the fold stage, chain[i+1] from rotator i
    stage_t chain [0:`CORDIC_STAGES];

    angle_fold u_angle_fold (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .angle    (angle),
        .stage    (chain[0])
    );

    for (genvar i = 0; i < `CORDIC_STAGES; i++) begin : g_rot
        cordic_rotator #(
            .STAGE_IDX (i)
        ) u_cordic_rotator (
            .clk       (clk),
            .rst_n     (rst_n),
            .stage_in  (chain[i]),
            .stage_out (chain[i+1])
        );
    end

    // z is dropped here, only x and y reach the outputs
    sincos_round u_sincos_round (
        .clk       (clk),
        .rst_n     (rst_n),
        .stage     (chain[`CORDIC_STAGES]),
        .out_valid (out_valid),
        .sine      (sine),
        .cosine    (cosine)
    );

endmodule

// ==== cordic_checker.sv ====
// samples DUT ports on the rising edge; expects a fixed 15-cycle latency, flushes on reset
`include "cordic_macros.svh"

module cordic_checker
    import cordic_fmt_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  angle_t angle,
    input  logic   out_valid,
    input  angle_t sine,
    input  angle_t cosine,
    output int     value_errs,
    output int     timing_errs,
    output int     flow_errs,
    output int     accuracy_errs
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LATENCY = 15;

    typedef struct packed {
        int     cyc;
        angle_t ang;
        angle_t sine;
        angle_t cosine;
    } expect_t;

    expect_t exp_q[$];
    expect_t head;
    int      cycle = 0;
    int      n_value = 0;
    int      n_timing = 0;
    int      n_flow = 0;
    int      n_accuracy = 0;
    logic    have_prev = 1'b0;
    logic    in_reset = 1'b0;
    angle_t  prev_ang;
    angle_t  prev_sine;
    angle_t  prev_cos;
    real     ref_val;

    assign value_errs    = n_value;
    assign timing_errs   = n_timing;
    assign flow_errs     = n_flow;
    assign accuracy_errs = n_accuracy;

    // keep a value inside the signed 14-bit range, as the hardware word does
    function automatic int wrap_word(input int v);
        int m;
        m = v & 32'h3fff;
        if (m >= 8192) begin
            m = m - 16384;
        end
        return m;
    endfunction

    // 14-bit Q1.12 to 8-bit Q1.6
    function automatic angle_t to_sample(input int w);
        logic [13:0] b;
        int          low;
        angle_t      res;
        b = 14'(w);
        if (b[12] == 1'b0) begin
            low = (int'(b[12:6]) + int'(b[5])) % 128;
            res = angle_t'({b[13], 7'(low)});
        end else begin
            res = angle_t'(b[13:6]);
        end
        return res;
    endfunction

    function automatic expect_t predict(input angle_t a, input int cyc);
        expect_t e;
        int      x;
        int      y;
        int      z;
        int      xs;
        int      ys;
        x = int'(word_t'(`CORDIC_GAIN));
        y = 0;
        z = ((a < 0) ? -int'(a) : int'(a)) * (1 << `FRAC_SHIFT);
        for (int i = 0; i < `CORDIC_STAGES; i++) begin
            xs = x >>> i;
            ys = y >>> i;
            if (z < 0) begin
                x = wrap_word(x + ys);
                y = wrap_word(y - xs);
                z = wrap_word(z + int'(atan_entry(i)));
            end else begin
                x = wrap_word(x - ys);
                y = wrap_word(y + xs);
                z = wrap_word(z - int'(atan_entry(i)));
            end
        end
        e.cyc    = cyc;
        e.ang    = a;
        e.sine   = (a < 0) ? angle_t'(-to_sample(y)) : to_sample(y);
        e.cosine = to_sample(x);
        return e;
    endfunction

    task automatic check_output(input expect_t e);
        if (cycle != e.cyc + LATENCY) begin
            n_timing++;
            $display("output for angle %0d came %0d cycles after its input instead of %0d",
                     e.ang, cycle - e.cyc, LATENCY);
        end
        if (sine !== e.sine) begin
            n_value++;
            $display("** Error at %0t: sine expected %0d, got %0d", $time, e.sine, sine);
        end
        if (cosine !== e.cosine) begin
            n_value++;
            $display("** Error at %0t: cosine expected %0d, got %0d", $time, e.cosine, cosine);
        end
        if (e.ang == 0 && sine !== 8'sd0) begin
            n_value++;
            $display("** Error at %0t: sine expected 0, got %0d", $time, sine);
        end
        // sine is odd, cosine is even
        if (have_prev && e.ang != 0 && e.ang == angle_t'(-prev_ang)) begin
            if (sine !== angle_t'(-prev_sine)) begin
                n_value++;
                $display("** Error at %0t: sine expected %0d, got %0d",
                         $time, angle_t'(-prev_sine), sine);
            end
            if (cosine !== prev_cos) begin
                n_value++;
                $display("** Error at %0t: cosine expected %0d, got %0d",
                         $time, prev_cos, cosine);
            end
        end
        ref_val = $sin(real'(e.ang) / 64.0) * 64.0;
        if (real'(sine) - ref_val > 2.0 || real'(sine) - ref_val < -2.0) begin
            n_accuracy++;
            $display("** Error at %0t: sine expected %f, got %0d", $time, ref_val, sine);
        end
        ref_val = $cos(real'(e.ang) / 64.0) * 64.0;
        if (real'(cosine) - ref_val > 2.0 || real'(cosine) - ref_val < -2.0) begin
            n_accuracy++;
            $display("** Error at %0t: cosine expected %f, got %0d", $time, ref_val, cosine);
        end
        have_prev = 1'b1;
        prev_ang  = e.ang;
        prev_sine = sine;
        prev_cos  = cosine;
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst_n) begin
            // one edge after reset is first sampled the output valid must be clear
            if (in_reset && out_valid !== 1'b0) begin
                n_flow++;
                $display("out_valid not cleared at %0t while reset is held", $time);
            end
            // anything still in flight is lost by the DUT
            exp_q.delete();
            have_prev = 1'b0;
            in_reset  = 1'b1;
        end else begin
            in_reset = 1'b0;
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    n_flow++;
                    $display("unexpected output at %0t with no angle pending", $time);
                end else begin
                    head = exp_q.pop_front();
                    check_output(head);
                end
            end else if (out_valid !== 1'b0) begin
                n_flow++;
                $display("out_valid is unknown at %0t", $time);
            end
            while (exp_q.size() > 0 && exp_q[0].cyc + LATENCY < cycle) begin
                head = exp_q.pop_front();
                n_flow++;
                $display("no output for angle %0d sent in cycle %0d", head.ang, head.cyc);
            end
            if (in_valid) begin
                exp_q.push_back(predict(angle, cycle));
            end
        end
    end

endmodule

// ==== tb_cordic_sincos.sv ====
// random stimulus from seed 63; angles stay within +/-ANGLE_LIMIT, the checker holds the model
`include "cordic_macros.svh"

module tb_cordic_sincos
    import cordic_fmt_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    // stream, gaps, sign pairs, corners, reset phase
    localparam int PLANNED_INPUTS = 400 + 200 + 2 * 50 + 5 + 34;
    localparam int WATCHDOG_CYCLES = 20 * PLANNED_INPUTS + 100;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    angle_t angle;
    logic   out_valid;
    angle_t sine;
    angle_t cosine;
    int     value_errs;
    int     timing_errs;
    int     flow_errs;
    int     accuracy_errs;
    angle_t pair_angle;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cordic_sincos u_cordic_sincos (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .angle     (angle),
        .out_valid (out_valid),
        .sine      (sine),
        .cosine    (cosine)
    );

    cordic_checker u_cordic_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .angle         (angle),
        .out_valid     (out_valid),
        .sine          (sine),
        .cosine        (cosine),
        .value_errs    (value_errs),
        .timing_errs   (timing_errs),
        .flow_errs     (flow_errs),
        .accuracy_errs (accuracy_errs)
    );

    function automatic angle_t random_angle();
        return angle_t'(int'($urandom_range(2 * `ANGLE_LIMIT)) - `ANGLE_LIMIT);
    endfunction

    // one input cycle, launched just after the rising edge
    task automatic send(input logic valid, input angle_t value);
        @(posedge clk);
        in_valid <= valid;
        angle    <= value;
    endtask

    // reset pulse while the stream keeps running
    task automatic pulse_reset(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            rst_n    <= 1'b0;
            in_valid <= 1'b1;
            angle    <= random_angle();
        end
        @(posedge clk);
        rst_n    <= 1'b1;
        in_valid <= 1'b0;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, stimulus did not finish", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        angle    = '0;
        void'($urandom(63));
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // back-to-back stream
        repeat (400) send(1'b1, random_angle());
        // idle cycles mixed in
        repeat (200) send(1'($urandom_range(1)), random_angle());
        // each angle followed by its negation
        repeat (50) begin
            pair_angle = random_angle();
            send(1'b1, pair_angle);
            send(1'b1, -pair_angle);
        end
        send(1'b1, 8'sd0);
        send(1'b1, 8'sd100);
        send(1'b1, -8'sd100);
        send(1'b1, 8'sd1);
        send(1'b1, -8'sd1);
        // reset with the pipeline full
        repeat (10) send(1'b1, random_angle());
        pulse_reset(4);
        repeat (20) send(1'b1, random_angle());
        repeat (20) send(1'b0, '0);
        @(posedge clk);

        $display("errors: value %0d, timing %0d, flow %0d, accuracy %0d",
                 value_errs, timing_errs, flow_errs, accuracy_errs);
        if (value_errs + timing_errs + flow_errs + accuracy_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
cordic_fmt_pkg.sv
cordic_pipe_pkg.sv
angle_fold.sv
cordic_rotator.sv
sincos_round.sv
cordic_sincos.sv
cordic_checker.sv
tb_cordic_sincos.sv

// ==== Bender.yml ====
package:
  name: cordic_sincos

sources:
  - include_dirs:
      - .
    files:
      - cordic_fmt_pkg.sv
      - cordic_pipe_pkg.sv
      - angle_fold.sv
      - cordic_rotator.sv
      - sincos_round.sv
      - cordic_sincos.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - cordic_checker.sv
      - tb_cordic_sincos.sv
